// File: bench/burstMemTb.sv
`timescale 1ns/1ps
`default_nettype none

module burstMemTb;
    import memBusPkg::*;
    import burstCfgPkg::*;

    localparam int memWords = 4096;
    localparam int maxLen = 300;
    localparam int numRandom = 24;
    localparam int waitLimit = 20000;

    logic clk;
    logic rst;
    logic cmdStrobe;
    memOp cmdOp;
    logic [reqLenBits-1:0] cmdLen;
    logic [addrBits-1:0] cmdAddr;
    logic cmdDropped;
    logic wrStrobe;
    logic [31:0] wrData;
    logic rdStrobe;
    logic [31:0] rdData;
    logic busy;
    logic extEn;
    logic extOen;
    logic [31:0] extBusOut;
    logic extStall;
    logic [31:0] extBusIn;
    logic hdrSeen;
    logic [31:0] hdrWord;
    logic oenClash;
    int wrCount;

    logic [31:0] refMem [memWords];
    logic [31:0] rdQ [$];
    logic [31:0] hdrQ [$];
    logic [31:0] expRdQ [$];
    logic [31:0] expHdrQ [$];
    int dropCount;
    int errors;
    int checks;
    integer seed;

    burstMemTop DUT (
        .clk        (clk),
        .rst        (rst),
        .cmdStrobe  (cmdStrobe),
        .cmdOp      (cmdOp),
        .cmdLen     (cmdLen),
        .cmdAddr    (cmdAddr),
        .cmdDropped (cmdDropped),
        .wrStrobe   (wrStrobe),
        .wrData     (wrData),
        .rdStrobe   (rdStrobe),
        .rdData     (rdData),
        .busy       (busy),
        .extEn      (extEn),
        .extOen     (extOen),
        .extBusOut  (extBusOut),
        .extStall   (extStall),
        .extBusIn   (extBusIn)
    );

    memDeviceModel devModel (
        .clk       (clk),
        .rst       (rst),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extStall  (extStall),
        .extBusIn  (extBusIn),
        .hdrSeen   (hdrSeen),
        .hdrWord   (hdrWord),
        .oenClash  (oenClash),
        .wrCount   (wrCount)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // Bus and host outputs are collected half a cycle after each edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (rdStrobe) begin
                rdQ.push_back(rdData);
            end
            if (hdrSeen) begin
                hdrQ.push_back(hdrWord);
            end
            if (cmdDropped) begin
                dropCount++;
            end
            if (oenClash) begin
                reportMismatch("extOen", 0, extOen);
            end
        end
    end

    // Preload pattern that mixes every address bit.
    function automatic logic [31:0] fillWord(input int addr);
        return (addr * 32'h9E3779B1) ^ 32'hC0DE0000 ^ addr;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
        errors++;
        $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic finishRun();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic abortRun(input string what);
        errors++;
        $display("Timeout at %0t while %s", $time, what);
        finishRun();
    endtask

    // One header per chunk of up to maxBurst words.
    task automatic expectHeaders(input memOp op, input int len, input int addr);
        int left;
        int a;
        int chunk;
        logic [31:0] hdr;
        left = len;
        a = addr;
        while (left > 0) begin
            chunk = (left > maxBurst) ? maxBurst : left;
            hdr = '0;
            hdr[hdrWriteBit] = (op == opWrite);
            hdr[hdrFullBit] = (chunk == maxBurst);
            hdr[addrBits-1:0] = addrBits'(a);
            expHdrQ.push_back(hdr);
            left -= chunk;
            a += chunk;
        end
    endtask

    task automatic expectReadData(input int len, input int addr);
        for (int i = 0; i < len; i++) begin
            expRdQ.push_back(refMem[addr + i]);
        end
    endtask

    task automatic strobeCommand(input memOp op, input int len, input int addr);
        @(posedge clk);
        cmdStrobe <= 1'b1;
        cmdOp <= op;
        cmdLen <= reqLenBits'(len);
        cmdAddr <= addrBits'(addr);
    endtask

    task automatic waitIdle();
        int guard;
        guard = 0;
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
            guard++;
            if (guard > waitLimit) begin
                abortRun("waiting for busy to fall");
            end
        end
    endtask

    task automatic compareResults();
        checks++;
        if (rdQ.size() != expRdQ.size()) begin
            reportMismatch("rdStrobe count", expRdQ.size(), rdQ.size());
        end else begin
            for (int i = 0; i < rdQ.size(); i++) begin
                checks++;
                if (rdQ[i] !== expRdQ[i]) begin
                    reportMismatch("rdData", expRdQ[i], rdQ[i]);
                end
            end
        end
        checks++;
        if (hdrQ.size() != expHdrQ.size()) begin
            reportMismatch("header count", expHdrQ.size(), hdrQ.size());
        end else begin
            for (int i = 0; i < hdrQ.size(); i++) begin
                checks++;
                if (hdrQ[i] !== expHdrQ[i]) begin
                    reportMismatch("extBusOut header", expHdrQ[i], hdrQ[i]);
                end
            end
        end
        for (int a = 0; a < memWords; a++) begin
            checks++;
            if (devModel.mem[a] !== refMem[a]) begin
                reportMismatch($sformatf("device mem[%0d]", a), refMem[a], devModel.mem[a]);
            end
        end
        rdQ.delete();
        hdrQ.delete();
        expRdQ.delete();
        expHdrQ.delete();
    endtask

    task automatic runRead(input int len, input int addr);
        expectHeaders(opRead, len, addr);
        expectReadData(len, addr);
        strobeCommand(opRead, len, addr);
        @(posedge clk);
        cmdStrobe <= 1'b0;
        waitIdle();
        compareResults();
    endtask

    // Prefill the write buffer, then send the command and keep it topped up.
    // Later pushes skip cycles at random, so the buffer can run dry mid-burst.
    task automatic runWrite(input int len, input int addr);
        int pushed;
        int guard;
        int startCount;
        int prefill;
        logic cmdSent;
        logic [31:0] word;
        pushed = 0;
        guard = 0;
        cmdSent = 1'b0;
        startCount = wrCount;
        prefill = (len < wrDepth) ? len : wrDepth;
        expectHeaders(opWrite, len, addr);
        while (pushed < len || !cmdSent) begin
            @(posedge clk);
            wrStrobe <= 1'b0;
            cmdStrobe <= 1'b0;
            if (!cmdSent && pushed == prefill) begin
                cmdStrobe <= 1'b1;
                cmdOp <= opWrite;
                cmdLen <= reqLenBits'(len);
                cmdAddr <= addrBits'(addr);
                cmdSent = 1'b1;
            end else if (pushed < len && pushed - (wrCount - startCount) < wrDepth
                         && (pushed < prefill || ($random(seed) & 1))) begin
                word = $random(seed);
                wrStrobe <= 1'b1;
                wrData <= word;
                refMem[addr + pushed] = word;
                pushed++;
            end
            guard++;
            if (guard > waitLimit) begin
                abortRun("pushing write data");
            end
        end
        @(posedge clk);
        wrStrobe <= 1'b0;
        cmdStrobe <= 1'b0;
        waitIdle();
        compareResults();
    endtask

    initial begin
        int len;
        int addr;
        int dropsBefore;
        seed = 64;
        errors = 0;
        checks = 0;
        dropCount = 0;
        rst = 1'b1;
        cmdStrobe = 1'b0;
        cmdOp = opRead;
        cmdLen = '0;
        cmdAddr = '0;
        wrStrobe = 1'b0;
        wrData = '0;
        for (int a = 0; a < memWords; a++) begin
            refMem[a] = fillWord(a);
            devModel.mem[a] = fillWord(a);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        checks += 5;
        if (extEn !== 1'b0) begin
            reportMismatch("extEn", 0, extEn);
        end
        if (rdStrobe !== 1'b0) begin
            reportMismatch("rdStrobe", 0, rdStrobe);
        end
        if (cmdDropped !== 1'b0) begin
            reportMismatch("cmdDropped", 0, cmdDropped);
        end
        if (busy !== 1'b0) begin
            reportMismatch("busy", 0, busy);
        end
        if (extOen !== 1'b1) begin
            reportMismatch("extOen", 1, extOen);
        end

        // Burst lengths right at and just past the bus limit.
        runRead(128, 100);
        runWrite(256, 1000);
        runRead(129, 2000);

        for (int n = 0; n < numRandom; n++) begin
            len = 1 + ($unsigned($random(seed)) % maxLen);
            addr = $unsigned($random(seed)) % (memWords - maxLen);
            if ($random(seed) & 1) begin
                runWrite(len, addr);
            end else begin
                runRead(len, addr);
            end
        end

        // Five back to back reads. The fifth finds the queue full.
        dropsBefore = dropCount;
        for (int n = 0; n < 5; n++) begin
            len = 1 + ($unsigned($random(seed)) % maxLen);
            addr = $unsigned($random(seed)) % (memWords - maxLen);
            if (n < cmdDepth) begin
                expectHeaders(opRead, len, addr);
                expectReadData(len, addr);
            end
            strobeCommand(opRead, len, addr);
        end
        @(posedge clk);
        cmdStrobe <= 1'b0;
        waitIdle();
        compareResults();
        checks++;
        if (dropCount - dropsBefore != 1) begin
            reportMismatch("cmdDropped pulses", 1, dropCount - dropsBefore);
        end

        finishRun();
    end

endmodule

`default_nettype wire

// File: bench/memDeviceModel.sv
`timescale 1ns/1ps
`default_nettype none

module memDeviceModel (
    input  logic        clk,
    input  logic        rst,
    input  logic        extEn,
    input  logic        extOen,
    input  logic [31:0] extBusOut,
    output logic        extStall,
    output logic [31:0] extBusIn,
    output logic        hdrSeen,
    output logic [31:0] hdrWord,
    output logic        oenClash,
    output int          wrCount
);
    import memBusPkg::*;

    localparam int memWords = 4096;

    logic [31:0] mem [memWords];
    logic inTxn;
    logic isWrite;
    logic inTurn;
    logic [11:0] addr;
    integer seed;

    initial begin
        seed = 64;
    end

    // The first enabled cycle of a transaction carries the header.
    assign hdrSeen = extEn && !inTxn;
    assign hdrWord = extBusOut;

    // After a read header the device owns the bus, so the master must not drive it.
    assign oenClash = extEn && inTxn && !isWrite && extOen;

    // Read data for the current word address.
    assign extBusIn = mem[addr];

    always @(posedge clk) begin
        if (rst) begin
            inTxn <= 1'b0;
            isWrite <= 1'b0;
            inTurn <= 1'b0;
            addr <= '0;
            extStall <= 1'b0;
            wrCount <= 0;
        end else begin
            // Stall about one cycle in four.
            extStall <= (($random(seed) & 3) == 0);
            if (!extEn) begin
                inTxn <= 1'b0;
            end else if (!inTxn) begin
                inTxn <= 1'b1;
                isWrite <= extBusOut[hdrWriteBit];
                inTurn <= !extBusOut[hdrWriteBit];
                addr <= extBusOut[11:0];
            end else if (isWrite) begin
                // A write word is on the bus only while the master drives it.
                if (extOen && !extStall) begin
                    mem[addr] <= extBusOut;
                    addr <= addr + 1'b1;
                    wrCount <= wrCount + 1;
                end
            end else if (inTurn) begin
                inTurn <= 1'b0;
            end else if (!extStall) begin
                addr <= addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: build.f
logic/memBusPkg.sv
logic/burstCfgPkg.sv
logic/wordFifo.sv
logic/burstSplitter.sv
logic/extBusMaster.sv
logic/burstMemTop.sv
bench/memDeviceModel.sv
bench/burstMemTb.sv

// File: logic/burstCfgPkg.sv
`default_nettype none

package burstCfgPkg;

    // A host request covers 1 to 1023 words.
    localparam int reqLenBits = 10;

    // A single bus burst covers 1 to 128 words.
    localparam int burstLenBits = 8;

    // Queue and buffer depths.
    localparam int cmdDepth = 4;
    localparam int wrDepth = 16;

    // One command queue entry is {op, len, addr}.
    localparam int cmdWidth = 1 + reqLenBits + memBusPkg::addrBits;

endpackage

`default_nettype wire

// File: logic/burstMemTop.sv
`timescale 1ns/1ps
`default_nettype none

module burstMemTop (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmdStrobe,
    input  memBusPkg::memOp                     cmdOp,
    input  logic [burstCfgPkg::reqLenBits-1:0]  cmdLen,
    input  logic [memBusPkg::addrBits-1:0]      cmdAddr,
    output logic                                cmdDropped,
    input  logic                                wrStrobe,
    input  logic [31:0]                         wrData,
    output logic                                rdStrobe,
    output logic [31:0]                         rdData,
    output logic                                busy,
    output logic                                extEn,
    output logic                                extOen,
    output logic [31:0]                         extBusOut,
    input  logic                                extStall,
    input  logic [31:0]                         extBusIn
);
    import memBusPkg::*;
    import burstCfgPkg::*;

    logic cmdValid;
    logic cmdPush;
    logic cmdPop;
    logic cmdFull;
    logic cmdNotEmpty;
    logic [cmdWidth-1:0] cmdHead;
    logic wrPop;
    logic wrNotEmpty;
    logic [31:0] wrHead;
    logic burstStart;
    logic burstBusy;
    logic splitActive;
    memOp burstOp;
    logic [burstLenBits-1:0] burstLen;
    logic [addrBits-1:0] burstAddr;

    // Zero-length requests never enter the queue.
    assign cmdValid = cmdStrobe && (cmdLen != '0);
    assign cmdPush = cmdValid && !cmdFull;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmdDropped <= 1'b0;
        end else begin
            cmdDropped <= cmdValid && cmdFull;
        end
    end

    assign busy = splitActive || burstBusy || cmdNotEmpty;

    wordFifo #(
        .width(cmdWidth),
        .depth(cmdDepth)
    ) cmdQueue (
        .clk      (clk),
        .rst      (rst),
        .push     (cmdPush),
        .pushData ({cmdOp, cmdLen, cmdAddr}),
        .pop      (cmdPop),
        .popData  (cmdHead),
        .notEmpty (cmdNotEmpty),
        .full     (cmdFull)
    );

    // The host keeps this buffer from overflowing.
    wordFifo #(
        .width(32),
        .depth(wrDepth)
    ) wrBuffer (
        .clk      (clk),
        .rst      (rst),
        .push     (wrStrobe),
        .pushData (wrData),
        .pop      (wrPop),
        .popData  (wrHead),
        .notEmpty (wrNotEmpty),
        .full     ()
    );

    burstSplitter splitter (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (cmdNotEmpty),
        .reqHead    (cmdHead),
        .reqPop     (cmdPop),
        .burstBusy  (burstBusy),
        .burstStart (burstStart),
        .burstOp    (burstOp),
        .burstLen   (burstLen),
        .burstAddr  (burstAddr),
        .active     (splitActive)
    );

    extBusMaster master (
        .clk        (clk),
        .rst        (rst),
        .burstStart (burstStart),
        .burstOp    (burstOp),
        .burstLen   (burstLen),
        .burstAddr  (burstAddr),
        .burstBusy  (burstBusy),
        .wrEmpty    (!wrNotEmpty),
        .wrPop      (wrPop),
        .wrData     (wrHead),
        .rdStrobe   (rdStrobe),
        .rdData     (rdData),
        .extEn      (extEn),
        .extOen     (extOen),
        .extBusOut  (extBusOut),
        .extStall   (extStall),
        .extBusIn   (extBusIn)
    );

endmodule

`default_nettype wire

// File: logic/burstSplitter.sv
`timescale 1ns/1ps
`default_nettype none

module burstSplitter (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  reqValid,
    input  logic [burstCfgPkg::cmdWidth-1:0]      reqHead,
    output logic                                  reqPop,
    input  logic                                  burstBusy,
    output logic                                  burstStart,
    output memBusPkg::memOp                       burstOp,
    output logic [burstCfgPkg::burstLenBits-1:0]  burstLen,
    output logic [memBusPkg::addrBits-1:0]        burstAddr,
    output logic                                  active
);
    import memBusPkg::*;
    import burstCfgPkg::*;

    typedef enum logic [1:0] {
        idle,
        issue,
        waitDone
    } splitState;

    localparam logic [reqLenBits-1:0] maxChunk = reqLenBits'(maxBurst);

    splitState state;
    memOp opReg;
    logic [reqLenBits-1:0] remLen;
    logic [reqLenBits-1:0] chunkLen;
    logic [addrBits-1:0] nextAddr;

    // Next burst is the rest of the request, capped at the bus limit.
    assign chunkLen = (remLen > maxChunk) ? maxChunk : remLen;

    assign burstOp = opReg;
    assign burstLen = chunkLen[burstLenBits-1:0];
    assign burstAddr = nextAddr;

    // Issue only while the master is idle.
    assign burstStart = (state == issue) && !burstBusy;

    // The queue slot is held until the whole request is done,
    // so the queue depth bounds the number of open requests.
    assign reqPop = (state == waitDone) && !burstBusy && (remLen == '0);

    assign active = (state != idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (reqValid) begin
                        state <= issue;
                    end
                end
                issue: begin
                    if (!burstBusy) begin
                        state <= waitDone;
                    end
                end
                waitDone: begin
                    // Master raises burstBusy right after the strobe.
                    if (!burstBusy) begin
                        state <= (remLen == '0) ? idle : issue;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request registers load from the queue head.
    always_ff @(posedge clk) begin
        if (state == idle && reqValid) begin
            opReg <= memOp'(reqHead[cmdWidth-1]);
            remLen <= reqHead[addrBits +: reqLenBits];
            nextAddr <= reqHead[addrBits-1:0];
        end else if (burstStart) begin
            remLen <= remLen - chunkLen;
            nextAddr <= nextAddr + addrBits'(chunkLen);
        end
    end

endmodule

`default_nettype wire

// File: logic/extBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

module extBusMaster (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  burstStart,
    input  memBusPkg::memOp                       burstOp,
    input  logic [burstCfgPkg::burstLenBits-1:0]  burstLen,
    input  logic [memBusPkg::addrBits-1:0]        burstAddr,
    output logic                                  burstBusy,
    input  logic                                  wrEmpty,
    output logic                                  wrPop,
    input  logic [31:0]                           wrData,
    output logic                                  rdStrobe,
    output logic [31:0]                           rdData,
    output logic                                  extEn,
    output logic                                  extOen,
    output logic [31:0]                           extBusOut,
    input  logic                                  extStall,
    input  logic [31:0]                           extBusIn
);
    import memBusPkg::*;
    import burstCfgPkg::*;

    // The header state covers the header cycle itself.
    // For a write it also covers one setup cycle before it, with extEn low.
    typedef enum logic [1:0] {
        idle,
        header,
        turnaround,
        data
    } busState;

    localparam logic [burstLenBits-1:0] fullLen = burstLenBits'(maxBurst);

    busState state;
    memOp opReg;
    logic fullReg;
    logic [addrBits-1:0] addrReg;
    logic [burstLenBits-1:0] wordsLeft;
    logic hdrWait;
    logic isWrite;
    logic wordMoved;
    logic lastWord;
    logic loadWord;

    function automatic logic [31:0] makeHeader(
        input memOp                op,
        input logic                full,
        input logic [addrBits-1:0] addr
    );
        logic [31:0] word;
        word = '0;
        word[hdrWriteBit] = (op == opWrite);
        word[hdrFullBit] = full;
        word[addrBits-1:0] = addr;
        return word;
    endfunction

    assign burstBusy = (state != idle);
    assign isWrite = (opReg == opWrite);
    assign lastWord = (wordsLeft == 1);

    // In a write data phase, extOen low means no word is on the bus.
    assign wordMoved = (state == data) && !extStall && (!isWrite || extOen);

    // Fetch the next write word whenever the bus slot is free.
    always_comb begin
        loadWord = 1'b0;
        if (isWrite && !wrEmpty) begin
            if (state == header && !hdrWait) begin
                loadWord = 1'b1;
            end else if (state == data) begin
                loadWord = !extOen || (wordMoved && !lastWord);
            end
        end
    end

    assign wrPop = loadWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            extEn <= 1'b0;
            extOen <= 1'b1;
            rdStrobe <= 1'b0;
        end else begin
            rdStrobe <= 1'b0;
            case (state)
                idle: begin
                    if (burstStart) begin
                        state <= header;
                        // Reads put the header out at once.
                        if (burstOp == opRead) begin
                            extEn <= 1'b1;
                            extOen <= 1'b1;
                        end
                    end
                end
                header: begin
                    if (hdrWait) begin
                        extEn <= 1'b1;
                        extOen <= 1'b1;
                    end else if (isWrite) begin
                        state <= data;
                        extOen <= loadWord;
                    end else begin
                        // Hand the bus to the device.
                        state <= turnaround;
                        extOen <= 1'b0;
                    end
                end
                turnaround: begin
                    state <= data;
                end
                data: begin
                    if (isWrite) begin
                        if (loadWord) begin
                            extOen <= 1'b1;
                        end else if (wordMoved && !lastWord) begin
                            extOen <= 1'b0;
                        end
                    end
                    if (wordMoved) begin
                        rdStrobe <= !isWrite;
                        if (lastWord) begin
                            state <= idle;
                            extEn <= 1'b0;
                            extOen <= 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Burst registers and bus data.
    always_ff @(posedge clk) begin
        if (state == idle && burstStart) begin
            opReg <= burstOp;
            fullReg <= (burstLen == fullLen);
            addrReg <= burstAddr;
            wordsLeft <= burstLen;
            hdrWait <= (burstOp == opWrite);
            if (burstOp == opRead) begin
                extBusOut <= makeHeader(burstOp, burstLen == fullLen, burstAddr);
            end
        end else begin
            if (state == header && hdrWait) begin
                hdrWait <= 1'b0;
                extBusOut <= makeHeader(opReg, fullReg, addrReg);
            end
            if (loadWord) begin
                extBusOut <= wrData;
            end
            if (wordMoved) begin
                wordsLeft <= wordsLeft - 1'b1;
            end
        end
    end

    // Read words are registered straight off the bus.
    always_ff @(posedge clk) begin
        if (wordMoved && !isWrite) begin
            rdData <= extBusIn;
        end
    end

endmodule

`default_nettype wire

// File: logic/memBusPkg.sv
`default_nettype none

package memBusPkg;

    // Opcode of a burst, carried in the write flag of the header word.
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } memOp;

    // Word address width on the external bus.
    localparam int addrBits = 30;

    // Longest burst the device accepts, in words.
    localparam int maxBurst = 128;

    // Header word layout.
    // Bit 31 is the write flag.
    // Bit 30 marks a burst of exactly maxBurst words.
    // Bits 29 to 0 hold the start word address.
    localparam int hdrWriteBit = 31;
    localparam int hdrFullBit = 30;

endpackage

`default_nettype wire

// File: logic/wordFifo.sv
`timescale 1ns/1ps
`default_nettype none

module wordFifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [width-1:0] pushData,
    input  logic             pop,
    output logic [width-1:0] popData,
    output logic             notEmpty,
    output logic             full
);
    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptrBits-1:0] lastSlot = ptrBits'(depth - 1);
    localparam logic [ptrBits:0] fullCount = (ptrBits + 1)'(depth);

    logic [width-1:0] mem [depth];
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits:0] count;
    logic doPush;
    logic doPop;

    // A push into a full FIFO is dropped, a pop from an empty one does nothing.
    assign doPush = push && !full;
    assign doPop = pop && notEmpty;

    assign full = (count == fullCount);
    assign notEmpty = (count != '0);

    // Head entry is visible without a pop.
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

`default_nettype wire
